// File: design/m72_pkg.sv
`default_nettype none

package m72_pkg;

    // ======================================================================
    // Bus widths
    // ======================================================================
    typedef logic [19:0] cpu_addr_t;    // CPU byte address
    typedef logic [15:0] word_t;
    typedef logic [24:0] sdr_addr_t;    // SDRAM word address

    // ======================================================================
    // CPU I/O port map
    // ======================================================================
    localparam logic [7:0] IO_SWITCHES = 8'h00;
    localparam logic [7:0] IO_FLAGS    = 8'h02;    // Also the system-flag register
    localparam logic [7:0] IO_DIP      = 8'h04;

    // CPU memory regions backed by SDRAM
    localparam logic [19:0] ROM_LIMIT = 20'h80000;
    localparam logic [19:0] RAM_START = 20'hA0000;
    localparam logic [19:0] RAM_LIMIT = 20'hA4000;

    localparam logic [24:0] SDR_ROM_BASE = 25'h0000000;
    localparam logic [24:0] SDR_RAM_BASE = 25'h0100000;

    // Divide-by-4 enable counters
    localparam int CE_DIV_BITS = 2;

endpackage

`default_nettype wire

// File: design/m72_ce_gen.sv
`timescale 1ns/100ps
`default_nettype none

module m72_ce_gen (
    input  logic CLK_32M,
    input  logic reset_n,
    input  logic mem_busy,
    output logic ce_cpu,
    output logic ce_4x_cpu,
    output logic ce_mcu
);

    localparam int W = m72_pkg::CE_DIV_BITS;
    localparam logic [W-1:0] ONE = 1;

    logic         run;        // Enables start one clock after reset release
    logic [W-1:0] cpu_cnt;
    logic [W-1:0] mcu_cnt;

    // CPU is held while the bridge waits on SDRAM
    assign ce_4x_cpu = run & ~mem_busy;
    assign ce_cpu    = ce_4x_cpu & (&cpu_cnt);
    assign ce_mcu    = &mcu_cnt;

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            run     <= 1'b0;
            cpu_cnt <= '0;
            mcu_cnt <= '0;
        end else begin
            run <= 1'b1;
            if (ce_4x_cpu) begin
                cpu_cnt <= cpu_cnt + ONE;
            end
            if (run) begin
                mcu_cnt <= mcu_cnt + ONE;    // MCU never stalls
            end
        end
    end

endmodule

`default_nettype wire

// File: design/m72_io_ports.sv
`timescale 1ns/100ps
`default_nettype none

module m72_io_ports #(
    parameter bit M84 = 1'b0
) (
    input  logic        CLK_32M,
    input  logic        reset_n,
    input  logic        io_rd,
    input  logic        io_wr,
    input  logic [7:0]  io_addr,
    input  logic [7:0]  io_wdata,
    output logic [7:0]  io_rdata,
    input  logic [3:0]  p1_joystick,
    input  logic [3:0]  p2_joystick,
    input  logic [3:0]  p1_buttons,
    input  logic [3:0]  p2_buttons,
    input  logic [1:0]  coin,
    input  logic [1:0]  start_buttons,
    input  logic        sprite_tnsl,
    input  logic [15:0] dip_sw,
    output logic        screen_flip,
    output logic        sound_brq,
    output logic        color_blank
);

    logic [15:0] switches;
    logic [15:0] flags;
    logic [15:0] io_word;
    logic [4:2]  sys_flags;    // Only the bits with a function on this board

    assign switches = {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
    assign flags    = {8'hff, sprite_tnsl, 3'b111, coin, start_buttons};

    // ======================================================================
    // Read side
    // ======================================================================
    always_comb begin
        case ({io_addr[7:1], 1'b0})
            m72_pkg::IO_SWITCHES: io_word = switches;
            m72_pkg::IO_FLAGS:    io_word = flags;
            m72_pkg::IO_DIP:      io_word = dip_sw;
            default:              io_word = 16'hffff;
        endcase
    end

    // Odd address takes the high byte, idle bus floats high
    assign io_rdata = !io_rd ? 8'hff : (io_addr[0] ? io_word[15:8] : io_word[7:0]);

    // ======================================================================
    // System-flag register
    // ======================================================================
    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            sys_flags <= '0;
        end else if (io_wr && io_addr == m72_pkg::IO_FLAGS) begin
            sys_flags <= io_wdata[4:2];
        end
    end

    assign color_blank = sys_flags[3];
    assign sound_brq   = ~M84 & ~sys_flags[4];      // M84 boards have no bus request
    assign screen_flip = ~sys_flags[2] ^ dip_sw[8]; // Flip DIP inverts the soft flip

endmodule

`default_nettype wire

// File: design/m72_sdram_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module m72_sdram_bridge (
    input  logic                CLK_32M,
    input  logic                reset_n,
    input  logic                mem_rd,
    input  logic                mem_wr,
    input  m72_pkg::cpu_addr_t  mem_addr,
    input  logic [1:0]          mem_sel,
    input  m72_pkg::word_t      mem_wdata,
    output m72_pkg::word_t      mem_rdata,
    output logic                mem_busy,
    output logic                sdr_req,
    output m72_pkg::sdr_addr_t  sdr_addr,
    output logic [1:0]          sdr_wr_sel,
    output m72_pkg::word_t      sdr_wdata,
    input  m72_pkg::word_t      sdr_rdata,
    input  logic                sdr_rdy
);

    logic               in_rom;
    logic               in_ram;
    m72_pkg::cpu_addr_t region_off;
    m72_pkg::sdr_addr_t region_addr;
    m72_pkg::word_t     word_out;
    logic [1:0]         word_sel;
    logic               mem_rd_d;
    logic               mem_wr_d;
    logic               start;
    logic               rdy_seen;
    m72_pkg::word_t     rdata_q;

    // ======================================================================
    // Region decode
    // ======================================================================
    assign in_rom = mem_addr < m72_pkg::ROM_LIMIT;
    assign in_ram = mem_addr >= m72_pkg::RAM_START && mem_addr < m72_pkg::RAM_LIMIT;

    assign region_off  = in_rom ? mem_addr : mem_addr - m72_pkg::RAM_START;
    assign region_addr = (in_rom ? m72_pkg::SDR_ROM_BASE : m72_pkg::SDR_RAM_BASE)
                       + {6'd0, region_off[19:1]};

    // Odd byte goes out on the upper lane
    assign word_out = mem_addr[0] ? {mem_wdata[7:0], 8'h00} : mem_wdata;
    assign word_sel = mem_addr[0] ? {mem_sel[0], 1'b0} : mem_sel;

    // One request per new CPU strobe
    assign start = !mem_busy && (in_rom || in_ram)
                && ((mem_rd && !mem_rd_d) || (mem_wr && !mem_wr_d));

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            mem_rd_d <= 1'b0;
            mem_wr_d <= 1'b0;
            sdr_req  <= 1'b0;
            mem_busy <= 1'b0;
            rdy_seen <= 1'b0;
        end else begin
            mem_rd_d <= mem_rd;
            mem_wr_d <= mem_wr;
            sdr_req  <= start;
            rdy_seen <= mem_busy & sdr_rdy;
            if (start) begin
                mem_busy <= 1'b1;
            end else if (rdy_seen) begin
                mem_busy <= 1'b0;    // Released the cycle after the data lands
            end
        end
    end

    always_ff @(posedge CLK_32M) begin
        if (start) begin
            sdr_addr   <= region_addr;
            sdr_wdata  <= word_out;
            sdr_wr_sel <= (mem_wr && in_ram) ? word_sel : 2'b00;    // ROM writes become reads
        end
        if (mem_busy && sdr_rdy) begin
            rdata_q <= sdr_rdata;
        end
    end

    // Upper byte comes down for odd addresses, unmapped reads float high
    assign mem_rdata = !(in_rom || in_ram) ? 16'hffff :
                       mem_addr[0] ? {8'h00, rdata_q[15:8]} : rdata_q;

endmodule

`default_nettype wire

// File: design/m72_pixel_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module m72_pixel_mixer (
    input  logic [4:0] char_r,
    input  logic [4:0] char_g,
    input  logic [4:0] char_b,
    input  logic       char_opaque,
    input  logic [7:0] obj_pix,
    input  logic [4:0] obj_pal_r,
    input  logic [4:0] obj_pal_g,
    input  logic [4:0] obj_pal_b,
    input  logic       en_sprites,
    input  logic       en_sprite_palette,
    input  logic       color_blank,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);

    logic       obj_opaque;
    logic       obj_wins;
    logic [4:0] obj_raw;
    logic [4:0] obj_r;
    logic [4:0] obj_g;
    logic [4:0] obj_b;

    // Pick a layer, expand to 8 bits and apply the blank
    function automatic logic [7:0] mix(input logic [4:0] obj, input logic [4:0] chr,
                                       input logic sel, input logic blank);
        logic [4:0] c;
        c = sel ? obj : chr;
        return blank ? 8'h00 : {c, c[4:2]};
    endfunction

    assign obj_opaque = (|obj_pix[3:0]) & en_sprites;
    assign obj_wins   = obj_opaque & char_opaque;

    assign obj_raw = {obj_pix[3:0], 1'b0};    // Palette bypass
    assign obj_r   = en_sprite_palette ? obj_pal_r : obj_raw;
    assign obj_g   = en_sprite_palette ? obj_pal_g : obj_raw;
    assign obj_b   = en_sprite_palette ? obj_pal_b : obj_raw;

    assign red   = mix(obj_r, char_r, obj_wins, color_blank);
    assign green = mix(obj_g, char_g, obj_wins, color_blank);
    assign blue  = mix(obj_b, char_b, obj_wins, color_blank);

endmodule

`default_nettype wire

// File: design/m72_audio_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module m72_audio_mixer (
    input  logic           CLK_32M,
    input  logic           reset_n,
    input  m72_pkg::word_t ym_audio,
    input  logic [7:0]     sample,
    output m72_pkg::word_t audio_l,
    output m72_pkg::word_t audio_r
);

    logic [7:0]     sample_s;    // Offset binary to two's complement
    logic [16:0]    sum;
    m72_pkg::word_t audio_q;

    assign sample_s = sample - 8'h80;
    assign sum      = {ym_audio[15], ym_audio} + {sample_s[7], sample_s, 8'h00};

    always_ff @(posedge CLK_32M or negedge reset_n) begin
        if (!reset_n) begin
            audio_q <= '0;
        end else begin
            audio_q <= sum[16:1];    // Halve to stay in range
        end
    end

    // Mono source on both channels
    assign audio_l = audio_q;
    assign audio_r = audio_q;

endmodule

`default_nettype wire

// File: design/m72_main_board.sv
`timescale 1ns/100ps
`default_nettype none

module m72_main_board #(
    parameter bit M84 = 1'b0
) (
    input  logic                CLK_32M,
    input  logic                reset_n,
    // Clock enables
    output logic                ce_cpu,
    output logic                ce_4x_cpu,
    output logic                ce_mcu,
    // CPU I/O bus
    input  logic                io_rd,
    input  logic                io_wr,
    input  logic [7:0]          io_addr,
    input  logic [7:0]          io_wdata,
    output logic [7:0]          io_rdata,
    input  logic [3:0]          p1_joystick,
    input  logic [3:0]          p2_joystick,
    input  logic [3:0]          p1_buttons,
    input  logic [3:0]          p2_buttons,
    input  logic [1:0]          coin,
    input  logic [1:0]          start_buttons,
    input  logic                sprite_tnsl,
    input  logic [15:0]         dip_sw,
    output logic                screen_flip,
    output logic                sound_brq,
    // CPU memory bus
    input  logic                mem_rd,
    input  logic                mem_wr,
    input  m72_pkg::cpu_addr_t  mem_addr,
    input  logic [1:0]          mem_sel,
    input  m72_pkg::word_t      mem_wdata,
    output m72_pkg::word_t      mem_rdata,
    // SDRAM port
    output logic                sdr_req,
    output m72_pkg::sdr_addr_t  sdr_addr,
    output logic [1:0]          sdr_wr_sel,
    output m72_pkg::word_t      sdr_wdata,
    input  m72_pkg::word_t      sdr_rdata,
    input  logic                sdr_rdy,
    // Video
    input  logic [4:0]          char_r,
    input  logic [4:0]          char_g,
    input  logic [4:0]          char_b,
    input  logic                char_opaque,
    input  logic [7:0]          obj_pix,
    input  logic [4:0]          obj_pal_r,
    input  logic [4:0]          obj_pal_g,
    input  logic [4:0]          obj_pal_b,
    input  logic                en_sprites,
    input  logic                en_sprite_palette,
    output logic [7:0]          red,
    output logic [7:0]          green,
    output logic [7:0]          blue,
    // Audio
    input  m72_pkg::word_t      ym_audio,
    input  logic [7:0]          sample,
    output m72_pkg::word_t      audio_l,
    output m72_pkg::word_t      audio_r
);

    logic mem_busy;
    logic color_blank;

    m72_ce_gen ce_gen_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n), .mem_busy(mem_busy),
        .ce_cpu(ce_cpu), .ce_4x_cpu(ce_4x_cpu), .ce_mcu(ce_mcu)
    );

    m72_io_ports #(.M84(M84)) io_ports_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .io_rd(io_rd), .io_wr(io_wr), .io_addr(io_addr),
        .io_wdata(io_wdata), .io_rdata(io_rdata),
        .p1_joystick(p1_joystick), .p2_joystick(p2_joystick),
        .p1_buttons(p1_buttons), .p2_buttons(p2_buttons),
        .coin(coin), .start_buttons(start_buttons),
        .sprite_tnsl(sprite_tnsl), .dip_sw(dip_sw),
        .screen_flip(screen_flip), .sound_brq(sound_brq), .color_blank(color_blank)
    );

    m72_sdram_bridge sdram_bridge_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_sel(mem_sel), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .mem_busy(mem_busy),
        .sdr_req(sdr_req), .sdr_addr(sdr_addr), .sdr_wr_sel(sdr_wr_sel),
        .sdr_wdata(sdr_wdata), .sdr_rdata(sdr_rdata), .sdr_rdy(sdr_rdy)
    );

    m72_pixel_mixer pixel_mixer_i (
        .char_r(char_r), .char_g(char_g), .char_b(char_b), .char_opaque(char_opaque),
        .obj_pix(obj_pix),
        .obj_pal_r(obj_pal_r), .obj_pal_g(obj_pal_g), .obj_pal_b(obj_pal_b),
        .en_sprites(en_sprites), .en_sprite_palette(en_sprite_palette),
        .color_blank(color_blank),
        .red(red), .green(green), .blue(blue)
    );

    m72_audio_mixer audio_mixer_i (
        .CLK_32M(CLK_32M), .reset_n(reset_n),
        .ym_audio(ym_audio), .sample(sample),
        .audio_l(audio_l), .audio_r(audio_r)
    );

endmodule

`default_nettype wire

// File: verif/m72_main_board_tb.sv
`timescale 1ns/100ps
`default_nettype none

module m72_main_board_tb;

    localparam int TIMEOUT_CYCLES = 4000;

    logic        CLK_32M = 1'b0;
    logic        reset_n;
    logic        ce_cpu, ce_4x_cpu, ce_mcu;
    logic        io_rd, io_wr, sprite_tnsl, screen_flip, sound_brq;
    logic [7:0]  io_addr, io_wdata, io_rdata;
    logic [3:0]  p1_joystick, p2_joystick, p1_buttons, p2_buttons;
    logic [1:0]  coin, start_buttons, mem_sel, sdr_wr_sel;
    logic [15:0] dip_sw, mem_wdata, mem_rdata, sdr_wdata, sdr_rdata;
    logic        mem_rd, mem_wr, sdr_req, sdr_rdy;
    logic [19:0] mem_addr;
    logic [24:0] sdr_addr;
    logic [4:0]  char_r, char_g, char_b, obj_pal_r, obj_pal_g, obj_pal_b;
    logic [7:0]  obj_pix, red, green, blue, sample;
    logic        char_opaque, en_sprites, en_sprite_palette;
    logic [15:0] ym_audio, audio_l, audio_r;

    integer      seed = 32'h9c82;
    int          cycles = 0;
    int          req_count = 0;
    int          rdy_wait = 0;
    logic [24:0] req_addr;
    logic [1:0]  req_sel;
    logic [15:0] req_wdata;
    logic [15:0] ram [0:63];    // Work RAM words by low address bits
    logic [4:2]  flags_model;
    logic [15:0] audio_exp;
    logic [7:0]  io_exp;
    logic [23:0] pix_exp;
    logic        flip_exp;
    logic        brq_exp;
    int          cpu_ticks, mcu_gap;
    bit          mcu_seen;

    m72_main_board dut_i (.*);

    always #10 CLK_32M = ~CLK_32M;

    // ======================================================================
    // Reference model
    // ======================================================================
    function automatic logic [15:0] rom_word(input logic [24:0] a);
        return a[15:0] ^ {a[24:16], 7'h35};
    endfunction

    function automatic logic [24:0] ref_sdr_addr(input logic [19:0] a);
        if (a < m72_pkg::ROM_LIMIT)
            return m72_pkg::SDR_ROM_BASE + a / 2;
        return m72_pkg::SDR_RAM_BASE + (a - m72_pkg::RAM_START) / 2;
    endfunction

    function automatic logic [7:0] ref_io(input logic rd, input logic [7:0] a);
        logic [15:0] w;
        case (a >> 1)
            0:       w = {p2_buttons, p2_joystick, p1_buttons, p1_joystick};
            1:       w = {8'hff, sprite_tnsl, 3'b111, coin, start_buttons};
            2:       w = dip_sw;
            default: w = 16'hffff;
        endcase
        if (!rd)
            return 8'hff;
        return a[0] ? w[15:8] : w[7:0];
    endfunction

    function automatic logic [23:0] ref_pixel(input logic blank);
        logic [4:0] r, g, b;
        {r, g, b} = {char_r, char_g, char_b};
        if (en_sprites && obj_pix[3:0] != 4'h0 && char_opaque) begin
            if (en_sprite_palette)
                {r, g, b} = {obj_pal_r, obj_pal_g, obj_pal_b};
            else
                {r, g, b} = {3{obj_pix[3:0], 1'b0}};
        end
        if (blank)
            return 24'h0;
        return {r, r[4:2], g, g[4:2], b, b[4:2]};
    endfunction

    function automatic logic [15:0] ref_audio(input logic [15:0] ym, input logic [7:0] s);
        int fm, smp, sum;
        fm  = $signed(ym);
        smp = s;
        sum = fm + (smp - 128) * 256;
        return sum[16:1];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge CLK_32M) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            report_error("the run did not finish within the cycle limit");
    end

    // ======================================================================
    // SDRAM model with random latency
    // ======================================================================
    always @(posedge CLK_32M) begin
        sdr_rdy <= 1'b0;
        if (sdr_req) begin
            req_count = req_count + 1;
            req_addr  = sdr_addr;
            req_sel   = sdr_wr_sel;
            req_wdata = sdr_wdata;
            if (sdr_addr >= m72_pkg::SDR_RAM_BASE) begin
                if (sdr_wr_sel[0]) ram[sdr_addr[5:0]][7:0] = sdr_wdata[7:0];
                if (sdr_wr_sel[1]) ram[sdr_addr[5:0]][15:8] = sdr_wdata[15:8];
            end
            rdy_wait = 1 + ($random(seed) & 7);
        end else if (rdy_wait > 0) begin
            rdy_wait = rdy_wait - 1;
            if (rdy_wait == 0) begin
                sdr_rdy   <= 1'b1;
                sdr_rdata <= (req_addr >= m72_pkg::SDR_RAM_BASE) ? ram[req_addr[5:0]]
                                                                  : rom_word(req_addr);
            end
        end
    end

    // Compare at the falling edge, where every output has settled
    always @(negedge CLK_32M) begin
        if (!reset_n) begin
            flags_model = '0;
            audio_exp   = '0;
            cpu_ticks   = 0;
            mcu_gap     = 0;
            mcu_seen    = 1'b0;
        end else begin
            io_exp   = ref_io(io_rd, io_addr);
            pix_exp  = ref_pixel(flags_model[3]);
            flip_exp = ~flags_model[2] ^ dip_sw[8];
            brq_exp  = ~flags_model[4];
            assert (io_rdata == io_exp) else report_mismatch("io_rdata", io_rdata, io_exp);
            assert ({red, green, blue} == pix_exp)
                else report_mismatch("red/green/blue", {red, green, blue}, pix_exp);
            assert (screen_flip == flip_exp)
                else report_mismatch("screen_flip", screen_flip, flip_exp);
            assert (sound_brq == brq_exp)
                else report_mismatch("sound_brq", sound_brq, brq_exp);
            assert (audio_l == audio_exp) else report_mismatch("audio_l", audio_l, audio_exp);
            assert (audio_r == audio_exp) else report_mismatch("audio_r", audio_r, audio_exp);
            assert (!(ce_cpu && dut_i.mem_busy))
                else report_error("ce_cpu pulsed while the SDRAM bridge was busy");
            assert (!mcu_seen || ce_4x_cpu == !dut_i.mem_busy)
                else report_mismatch("ce_4x_cpu", ce_4x_cpu, !dut_i.mem_busy);
            mcu_gap = mcu_gap + 1;
            if (ce_4x_cpu) cpu_ticks = cpu_ticks + 1;
            if (ce_cpu) begin
                assert (cpu_ticks == 4) else report_mismatch("ce_cpu", cpu_ticks, 4);
                cpu_ticks = 0;
            end else begin
                assert (cpu_ticks < 4)
                    else report_error("ce_cpu did not pulse after four enabled clocks");
            end
            if (ce_mcu) begin
                assert (!mcu_seen || mcu_gap == 4) else report_mismatch("ce_mcu", mcu_gap, 4);
                mcu_gap  = 0;
                mcu_seen = 1'b1;
            end else begin
                assert (!mcu_seen || mcu_gap < 4)
                    else report_error("ce_mcu did not pulse after four clocks");
            end
            if (io_wr && io_addr == m72_pkg::IO_FLAGS) flags_model = io_wdata[4:2];
            audio_exp = ref_audio(ym_audio, sample);    // Registered on the next edge
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic drive_random();
        @(posedge CLK_32M);
        io_rd    <= ($random(seed) & 3) != 0;
        io_wr    <= $random(seed) & 1;
        io_addr  <= ($random(seed) & 1) ? ($random(seed) & 7) : $random(seed);
        io_wdata <= $random(seed);
        {p1_joystick, p2_joystick, p1_buttons, p2_buttons} <= $random(seed);
        {coin, start_buttons, sprite_tnsl} <= $random(seed);
        dip_sw   <= $random(seed);
        {char_r, char_g, char_b, char_opaque, obj_pix} <= $random(seed);
        {obj_pal_r, obj_pal_g, obj_pal_b, en_sprites, en_sprite_palette} <= $random(seed);
        {ym_audio, sample} <= $random(seed);
    endtask

    task automatic mem_access(input logic wr, input logic [19:0] addr,
                              input logic [1:0] sel, input logic [15:0] wdata);
        int          n0;
        logic        in_ram;
        logic        mapped;
        logic [1:0]  sel_exp;
        logic [15:0] w;
        logic [15:0] rd_exp;
        n0      = req_count;
        in_ram  = addr >= m72_pkg::RAM_START && addr < m72_pkg::RAM_LIMIT;
        mapped  = in_ram || addr < m72_pkg::ROM_LIMIT;
        sel_exp = !(wr && in_ram) ? 2'b00 : addr[0] ? {sel[0], 1'b0} : sel;
        @(posedge CLK_32M);
        mem_addr  <= addr;
        mem_sel   <= sel;
        mem_wdata <= wdata;
        mem_rd    <= !wr;
        mem_wr    <= wr;
        repeat (3) @(posedge CLK_32M);
        while (dut_i.mem_busy) @(posedge CLK_32M);
        assert (req_count == n0 + mapped) else report_mismatch("sdr_req", req_count - n0, mapped);
        if (mapped) begin
            assert (req_addr == ref_sdr_addr(addr))
                else report_mismatch("sdr_addr", req_addr, ref_sdr_addr(addr));
            assert (req_sel == sel_exp) else report_mismatch("sdr_wr_sel", req_sel, sel_exp);
            if (wr && in_ram) begin
                w = addr[0] ? {wdata[7:0], 8'h00} : wdata;
                assert (req_wdata[15:8] == w[15:8] || !sel_exp[1])
                    else report_mismatch("sdr_wdata", req_wdata, w);
                assert (req_wdata[7:0] == w[7:0] || !sel_exp[0])
                    else report_mismatch("sdr_wdata", req_wdata, w);
            end
        end
        if (!wr) begin
            w      = in_ram ? ram[ref_sdr_addr(addr) & 63] : rom_word(ref_sdr_addr(addr));
            rd_exp = !mapped ? 16'hffff : addr[0] ? {8'h00, w[15:8]} : w;
            assert (mem_rdata == rd_exp) else report_mismatch("mem_rdata", mem_rdata, rd_exp);
        end
        mem_rd <= 1'b0;
        mem_wr <= 1'b0;
        @(posedge CLK_32M);
    endtask

    initial begin
        logic [19:0] ram_addr;
        reset_n = 1'b0;
        {io_rd, io_wr, io_addr, io_wdata, sprite_tnsl, dip_sw} = '0;
        {p1_joystick, p2_joystick, p1_buttons, p2_buttons, coin, start_buttons} = '0;
        {mem_rd, mem_wr, mem_addr, mem_sel, mem_wdata, sdr_rdata, sdr_rdy} = '0;
        {char_r, char_g, char_b, char_opaque, obj_pix, obj_pal_r, obj_pal_g, obj_pal_b} = '0;
        {en_sprites, en_sprite_palette, ym_audio, sample} = '0;
        for (int i = 0; i < 64; i++)
            ram[i] = {2'b10, i[5:0], ~i[5:0], 2'b01};
        repeat (8) @(posedge CLK_32M);
        reset_n <= 1'b1;

        // I/O map, flag register, pixel and audio paths
        repeat (600) drive_random();

        // SDRAM bridge accesses
        for (int i = 0; i < 20; i++) begin
            ram_addr = m72_pkg::RAM_START + ($random(seed) & 8'h7f);
            mem_access(1'b1, ram_addr, $random(seed), $random(seed));
            mem_access(1'b0, ram_addr, 2'b11, 16'h0);
            mem_access(1'b0, $random(seed) & 20'h7ffff, 2'b11, 16'h0);
            mem_access(1'b1, $random(seed) & 20'h7ffff, $random(seed), $random(seed));
            mem_access(!i[0], 20'hc0000 + ($random(seed) & 16'hffff), 2'b11, $random(seed));
        end

        repeat (4) @(posedge CLK_32M);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/m72_pkg.sv
design/m72_ce_gen.sv
design/m72_io_ports.sv
design/m72_sdram_bridge.sv
design/m72_pixel_mixer.sv
design/m72_audio_mixer.sv
design/m72_main_board.sv
verif/m72_main_board_tb.sv
